//--- Makefile
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// major opcodes as the ISA manual lists them
localparam logic [6:0] op_lui    = 7'b0110111;
localparam logic [6:0] op_auipc  = 7'b0010111;
localparam logic [6:0] op_jal    = 7'b1101111;
localparam logic [6:0] op_jalr   = 7'b1100111;
localparam logic [6:0] op_branch = 7'b1100011;
localparam logic [6:0] op_load   = 7'b0000011;
localparam logic [6:0] op_store  = 7'b0100011;
localparam logic [6:0] op_imm    = 7'b0010011;
localparam logic [6:0] op_reg    = 7'b0110011;
localparam logic [31:0] ecall_insn = 32'h0000_0073;

// what one instruction should show on the core ports
typedef struct packed {
  logic [31:0] pc;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  strb;
  logic        mem_access;
  logic        halt;
} expect_t;

logic [31:0] model_pc;
logic [31:0] model_regs [0:31];
logic [31:0] model_mem [0:255];

function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << sh;
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic void reset_model();
  model_pc = '0;
  for (int r = 0; r < 32; r++)
    model_regs[r] = '0;
endfunction

// runs one instruction and returns what the core should present for it
function automatic expect_t step_model(input logic [31:0] insn);
  expect_t     e;
  logic [6:0]  opc;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] ea;
  logic [31:0] sh;
  logic [31:0] npc;
  logic [31:0] wr;
  logic        wr_en;
  logic        take;
  opc   = insn[6:0];
  rd    = insn[11:7];
  f3    = insn[14:12];
  a     = model_regs[insn[19:15]];
  b     = model_regs[insn[24:20]];
  e     = '0;
  e.pc  = model_pc;
  npc   = model_pc + 32'd4;
  wr    = model_pc + 32'd4;
  wr_en = 1'b1;
  case (opc)
    op_lui:   wr = {insn[31:12], 12'h000};
    op_auipc: wr = model_pc + {insn[31:12], 12'h000};
    op_jal: begin
      npc = model_pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end
    op_jalr:  npc = (a + {{20{insn[31]}}, insn[31:20]}) & ~32'd1;
    op_branch: begin
      wr_en = 1'b0;
      case (f3)
        3'b000:  take = (a == b);
        3'b001:  take = (a != b);
        3'b100:  take = $signed(a) < $signed(b);
        3'b101:  take = $signed(a) >= $signed(b);
        3'b110:  take = a < b;
        3'b111:  take = a >= b;
        default: take = 1'b0;
      endcase
      if (take)
        npc = model_pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    end
    op_load: begin
      ea           = a + {{20{insn[31]}}, insn[31:20]};
      e.addr       = {ea[31:2], 2'b00};
      e.mem_access = 1'b1;
      sh           = model_mem[ea[9:2]] >> {ea[1:0], 3'b000};
      case (f3)
        3'b000:  wr = {{24{sh[7]}}, sh[7:0]};
        3'b001:  wr = {{16{sh[15]}}, sh[15:0]};
        3'b100:  wr = {24'b0, sh[7:0]};
        3'b101:  wr = {16'b0, sh[15:0]};
        default: wr = sh;
      endcase
    end
    op_store: begin
      wr_en        = 1'b0;
      ea           = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
      e.addr       = {ea[31:2], 2'b00};
      e.mem_access = 1'b1;
      case (f3)
        3'b000: begin
          e.strb  = 4'b0001 << ea[1:0];
          e.wdata = {24'b0, b[7:0]} << {ea[1:0], 3'b000};
        end
        3'b001: begin
          e.strb  = 4'b0011 << ea[1:0];
          e.wdata = {16'b0, b[15:0]} << {ea[1:0], 3'b000};
        end
        default: begin
          e.strb  = 4'b1111;
          e.wdata = b;
        end
      endcase
      for (int k = 0; k < 4; k++)
        if (e.strb[k])
          model_mem[ea[9:2]][8*k +: 8] = e.wdata[8*k +: 8];
    end
    op_imm:   wr = compute_alu(f3, insn[30] && f3 == 3'b101, a, {{20{insn[31]}}, insn[31:20]});
    op_reg:   wr = compute_alu(f3, insn[30], a, b);
    default: begin
      // fence is a no-op, ecall parks on itself
      wr_en  = 1'b0;
      e.halt = (insn == ecall_insn);
      if (e.halt)
        npc = model_pc;
    end
  endcase
  if (wr_en && rd != 5'd0)
    model_regs[rd] = wr;
  model_pc = npc;
  return e;
endfunction

`endif

//--- verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_isa_pkg::*, core_pkg::*;
();

  localparam int prog_len = 150;
  localparam int mem_words = 256;
  localparam int timeout_cycles = 2 * prog_len + 20;
  // cycles spent watching the parked core before passing
  localparam int halt_cycles = 4;
  localparam int jalr_slot = 100;

  logic      clk;
  logic      rst;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      halt;

  word_t imem [0:mem_words-1];
  word_t dmem [0:mem_words-1];

  `include "rv_ref_model.svh"

  rv_core u_rv_core (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  always #5 clk = ~clk;

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    for (int k = 0; k < 4; k++)
      if (dmem_req.strb[k])
        dmem[dmem_req.addr[9:2]][8*k +: 8] <= dmem_req.wdata[8*k +: 8];
  end

  task automatic stop_on_mismatch(input string name, input word_t exp, input word_t got);
    $display("FAILED %s expected 0x%08h got 0x%08h", name, exp, got);
    $display("RESULT: FAIL");
    $fatal(1, "%s does not match the model", name);
  endtask

  task automatic compare_word(input string name, input word_t exp, input word_t got);
    assert (got == exp) else stop_on_mismatch(name, exp, got);
  endtask

  task automatic check_ports(input expect_t e);
    word_t mask;
    for (int k = 0; k < 4; k++)
      mask[8*k +: 8] = {8{e.strb[k]}};
    compare_word("imem_addr", e.pc, imem_addr);
    compare_word("halt", word_t'(e.halt), word_t'(halt));
    compare_word("dmem_req.strb", word_t'(e.strb), word_t'(dmem_req.strb));
    if (e.mem_access)
      compare_word("dmem_req.addr", e.addr, dmem_req.addr);
    // only the written lanes carry meaning
    if (e.strb != 4'b0000)
      compare_word("dmem_req.wdata", e.wdata & mask, dmem_req.wdata & mask);
  endtask

  // offset from x0 that stays in data memory and suits the access size
  function automatic int aligned_offset(input logic [1:0] size);
    case (size)
      2'b00:   return int'($urandom_range(1023, 0));
      2'b01:   return int'($urandom_range(511, 0)) * 2;
      default: return int'($urandom_range(255, 0)) * 4;
    endcase
  endfunction

  task automatic build_program();
    int unsigned kind;
    int          skip;
    int          limit;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    for (int i = 0; i < prog_len - 1; i++) begin
      // nothing may jump past the lui that feeds the jalr
      limit = (i < jalr_slot) ? jalr_slot : prog_len - 1;
      skip  = int'($urandom_range(4, 1));
      if (i + skip > limit)
        skip = limit - i;
      kind = $urandom_range(99, 0);
      // a store at address 0 sits on the bus while reset gates the strobes
      if (i == 0)
        kind = 70;
      rd   = 5'($urandom_range(7, 0));
      rs1  = 5'($urandom_range(7, 0));
      rs2  = 5'($urandom_range(7, 0));
      f3   = 3'($urandom_range(7, 0));
      if (i == jalr_slot) begin
        // program sits below 4 KiB so the upper part is zero
        imem[i] = u_format(20'h00000, 5'd5, op_lui);
      end else if (i == jalr_slot + 1) begin
        // odd target, bit 0 must be dropped
        imem[i] = i_format(12'((jalr_slot + 4) * 4 + 1), 5'd5, 3'b000, 5'd6, op_jalr);
      end else if (kind < 30) begin
        imm12 = 12'($urandom);
        if (f3 == 3'b001)
          imm12 = {7'b0, imm12[4:0]};
        else if (f3 == 3'b101)
          imm12 = {1'b0, imm12[11], 5'b0, imm12[4:0]};
        imem[i] = i_format(imm12, rs1, f3, rd, op_imm);
      end else if (kind < 50) begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        imem[i] = r_format(f7, rs2, rs1, f3, rd, op_reg);
      end else if (kind < 55) begin
        imem[i] = u_format(20'($urandom), rd, op_lui);
      end else if (kind < 60) begin
        imem[i] = u_format(20'($urandom), rd, op_auipc);
      end else if (kind < 70) begin
        f3 = 3'($urandom_range(4, 0));
        if (f3 >= 3'd3)
          f3 = f3 + 3'd1;
        imem[i] = i_format(12'(aligned_offset(f3[1:0])), 5'd0, f3, rd, op_load);
      end else if (kind < 85) begin
        f3 = 3'($urandom_range(2, 0));
        imem[i] = s_format(12'(aligned_offset(f3[1:0])), rs2, 5'd0, f3);
      end else if (kind < 95) begin
        // 0..5 onto beq, bne, blt, bge, bltu, bgeu
        f3 = 3'($urandom_range(5, 0));
        if (f3 >= 3'd2)
          f3 = f3 + 3'd2;
        imem[i] = b_format(13'(skip * 4), rs2, rs1, f3);
      end else begin
        imem[i] = j_format(21'(skip * 4), rd);
      end
    end
    imem[prog_len-1] = ecall_insn;
  endtask

  initial begin
    expect_t e;
    int      parked;
    void'($urandom(27));
    clk = 1'b0;
    rst = 1'b1;
    for (int w = 0; w < mem_words; w++) begin
      dmem[w]      = word_t'((w + 1) * 32'h9e37_79b9);
      model_mem[w] = dmem[w];
    end
    build_program();
    reset_model();
    repeat (4) begin
      @(posedge clk);
      #1;
      compare_word("imem_addr", '0, imem_addr);
      compare_word("dmem_req.strb", '0, word_t'(dmem_req.strb));
    end
    rst = 1'b0;
    parked = 0;
    // lockstep against the model, sampled mid cycle
    while (parked < halt_cycles) begin
      @(negedge clk);
      e = step_model(imem[model_pc[9:2]]);
      check_ports(e);
      if (e.halt)
        parked++;
    end
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("RESULT: FAIL");
    $fatal(1, "timeout, the core did not halt within %0d cycles", timeout_cycles);
  end

endmodule

//--- verilog.f
+incdir+verification
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/insn_decoder.sv
verilog/alu.sv
verilog/next_pc.sv
verilog/load_store_unit.sv
verilog/rv_core.sv
verification/tb_rv_core.sv

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*, rv_isa_pkg::word_t; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic [$clog2($bits(word_t))-1:0] shamt;

  assign shamt = b[$clog2($bits(word_t))-1:0];

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      end
      alu_sltu: begin
        result = (a < b) ? word_t'(1) : '0;
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = word_t'($signed(a) >>> shamt);
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      // lui
      alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- verilog/core_pkg.sv
package core_pkg;
  import rv_isa_pkg::*;

  localparam int strb_w = xlen / 8;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic {
    src_rs1,
    src_pc
  } src_a_e;

  typedef struct packed {
    alu_op_e    alu_op;
    src_a_e     src_a;
    logic       use_imm;
    logic       reg_write;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       halt;
    // also carries the branch condition
    logic [2:0] mem_funct3;
  } ctrl_t;

  // does nothing and writes nothing
  localparam ctrl_t ctrl_nop = '{
    alu_op:     alu_add,
    src_a:      src_rs1,
    use_imm:    1'b0,
    reg_write:  1'b0,
    is_load:    1'b0,
    is_store:   1'b0,
    is_branch:  1'b0,
    is_jal:     1'b0,
    is_jalr:    1'b0,
    halt:       1'b0,
    mem_funct3: 3'b000
  };

  typedef struct packed {
    word_t             addr;
    word_t             wdata;
    logic [strb_w-1:0] strb;
  } dmem_req_t;

endpackage

//--- verilog/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder import rv_isa_pkg::*, core_pkg::*; (
  input  insn_t insn,
  output ctrl_t ctrl,
  output word_t imm
);

  logic [6:0] f7;
  logic [2:0] f3;
  logic       alt;
  logic       legal;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic sub_sra);
    alu_op_e op;
    case (funct3)
      f3_add:  op = sub_sra ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = sub_sra ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign f7  = insn.r.funct7;
  assign f3  = insn.r.funct3;
  assign alt = (f7 == funct7_alt);

  // immediates, sign bit always insn[31]
  assign imm_i = {{20{f7[6]}}, f7, insn.r.rs2};
  assign imm_s = {{20{f7[6]}}, f7, insn.r.rd};
  assign imm_b = {{19{f7[6]}}, f7[6], insn.r.rd[0], f7[5:0], insn.r.rd[4:1], 1'b0};
  assign imm_j = {{11{f7[6]}}, f7[6], insn.r.rs1, f3, insn.r.rs2[0], f7[5:0],
                  insn.r.rs2[4:1], 1'b0};
  assign imm_u = {insn.u.imm_hi, 12'h000};

  always_comb begin
    ctrl  = ctrl_nop;
    imm   = '0;
    legal = 1'b0;
    case (insn.r.opcode)
      opc_lui: begin
        ctrl.alu_op    = alu_pass_b;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      opc_auipc: begin
        ctrl.src_a     = src_pc;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      opc_jal: begin
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_j;
      end
      opc_jalr: begin
        ctrl.is_jalr   = (f3 == 3'b000);
        ctrl.reg_write = (f3 == 3'b000);
        imm            = imm_i;
      end
      opc_branch: begin
        // 010 and 011 are not branch conditions
        ctrl.is_branch  = (f3[2:1] != 2'b01);
        ctrl.mem_funct3 = f3;
        imm             = imm_b;
      end
      opc_load: begin
        legal           = (f3 == f3_byte) || (f3 == f3_half) || (f3 == f3_word) ||
                          (f3 == f3_byte_u) || (f3 == f3_half_u);
        ctrl.is_load    = legal;
        ctrl.reg_write  = legal;
        ctrl.use_imm    = 1'b1;
        ctrl.mem_funct3 = f3;
        imm             = imm_i;
      end
      opc_store: begin
        ctrl.is_store   = (f3 == f3_byte) || (f3 == f3_half) || (f3 == f3_word);
        ctrl.use_imm    = 1'b1;
        ctrl.mem_funct3 = f3;
        imm             = imm_s;
      end
      opc_op_imm: begin
        legal = 1'b1;
        if (f3 == f3_sll) legal = (f7 == '0);
        if (f3 == f3_sr) legal = (f7 == '0) || alt;
        // addi has no sub form, only srai uses the alt bit
        ctrl.alu_op    = alu_sel(f3, alt && f3 == f3_sr);
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = legal;
        imm            = imm_i;
      end
      opc_op: begin
        legal          = (f7 == '0) || (alt && (f3 == f3_add || f3 == f3_sr));
        ctrl.alu_op    = alu_sel(f3, alt);
        ctrl.reg_write = legal;
      end
      opc_system: begin
        // ecall only, everything else in the word is zero
        ctrl.halt = ({f7, insn.r.rs2, insn.r.rs1, f3, insn.r.rd} == '0);
      end
      default: begin
        // fence and unknown encodings fall through as a no-op
        ctrl = ctrl_nop;
      end
    endcase
  end

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import rv_isa_pkg::*, core_pkg::*; (
  input  logic      rst,
  input  ctrl_t     ctrl,
  input  word_t     addr,
  input  word_t     rs2_data,
  input  word_t     dmem_rdata,
  output dmem_req_t dmem_req,
  output word_t     load_result
);

  logic [1:0]        ofs;
  logic [strb_w-1:0] strb;
  word_t             wdata;
  word_t             rd_shift;

  // byte offset within the word
  assign ofs = addr[1:0];

  // store lanes, bytes outside the strobe are zero
  always_comb begin
    case (ctrl.mem_funct3)
      f3_byte: begin
        strb  = 4'b0001 << ofs;
        wdata = word_t'(rs2_data[7:0]) << {ofs, 3'b000};
      end
      f3_half: begin
        strb  = 4'b0011 << {ofs[1], 1'b0};
        wdata = word_t'(rs2_data[15:0]) << {ofs[1], 4'b0000};
      end
      default: begin
        strb  = '1;
        wdata = rs2_data;
      end
    endcase
  end

  assign dmem_req.addr  = {addr[xlen-1:2], 2'b00};
  assign dmem_req.wdata = wdata;
  // no writes may reach memory while in reset
  assign dmem_req.strb  = (ctrl.is_store && !rst) ? strb : '0;

  // addressed byte or halfword moved down to bit 0
  assign rd_shift = dmem_rdata >> {ofs, 3'b000};

  always_comb begin
    case (ctrl.mem_funct3)
      f3_byte:   load_result = {{(xlen - 8){rd_shift[7]}}, rd_shift[7:0]};
      f3_half:   load_result = {{(xlen - 16){rd_shift[15]}}, rd_shift[15:0]};
      f3_byte_u: load_result = {{(xlen - 8){1'b0}}, rd_shift[7:0]};
      f3_half_u: load_result = {{(xlen - 16){1'b0}}, rd_shift[15:0]};
      default:   load_result = dmem_rdata;
    endcase
  end

  // lh, lhu and sh all share funct3 low bits 01
  always_comb begin
    if (!rst && (ctrl.is_load || ctrl.is_store) && ctrl.mem_funct3[1:0] == 2'b01) begin
      a_half_aligned : assert final (addr[0] == 1'b0);
    end
  end

endmodule

//--- verilog/next_pc.sv
`timescale 1ns/1ps

module next_pc import rv_isa_pkg::*, core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  word_t imm,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t pc
);

  logic  take;
  word_t jalr_tgt;
  word_t pc_nxt;

  always_comb begin
    case (ctrl.mem_funct3)
      f3_beq:  take = (rs1_data == rs2_data);
      f3_bne:  take = (rs1_data != rs2_data);
      f3_blt:  take = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  take = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: take = (rs1_data < rs2_data);
      f3_bgeu: take = (rs1_data >= rs2_data);
      default: take = 1'b0;
    endcase
  end

  assign jalr_tgt = rs1_data + imm;

  always_comb begin
    if (ctrl.halt) begin
      // park on the ecall
      pc_nxt = pc;
    end else if (ctrl.is_jalr) begin
      pc_nxt = {jalr_tgt[xlen-1:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && take)) begin
      pc_nxt = pc + imm;
    end else begin
      pc_nxt = pc + word_t'(insn_bytes);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_nxt;
    end
  end

  a_pc_aligned : assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  reg_idx_t rd_idx,
  input  word_t    rd_data,
  input  logic     write_en,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  // entry 0 is cleared by reset and skipped by the write port
  word_t regs [0:num_regs-1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  // x0 reads zero on both ports
  a_x0_zero : assert property (@(posedge clk) disable iff (rst)
    (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0));

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  output logic      halt
);

  insn_t insn;
  ctrl_t ctrl;
  word_t imm;
  word_t pc;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t load_result;
  word_t wb_data;

  assign insn      = imem_data;
  assign imem_addr = pc;
  assign halt      = ctrl.halt;

  insn_decoder u_insn_decoder (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (insn.r.rs1),
    .rs2_idx  (insn.r.rs2),
    .rd_idx   (insn.r.rd),
    .rd_data  (wb_data),
    .write_en (ctrl.reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // auipc takes pc on the a side
  assign alu_a = (ctrl.src_a == src_pc) ? pc : rs1_data;
  assign alu_b = ctrl.use_imm ? imm : rs2_data;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  next_pc u_next_pc (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .imm      (imm),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc)
  );

  load_store_unit u_load_store_unit (
    .rst         (rst),
    .ctrl        (ctrl),
    .addr        (alu_result),
    .rs2_data    (rs2_data),
    .dmem_rdata  (dmem_rdata),
    .dmem_req    (dmem_req),
    .load_result (load_result)
  );

  // link address for jal and jalr
  always_comb begin
    if (ctrl.is_load) begin
      wb_data = load_result;
    end else if (ctrl.is_jal || ctrl.is_jalr) begin
      wb_data = pc + word_t'(insn_bytes);
    end else begin
      wb_data = alu_result;
    end
  end

  // once stopped on ecall the core stays there
  a_halt_sticky : assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && $stable(imem_addr));

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 2 ** reg_addr_w;
  // every instruction is one word
  localparam int insn_bytes = 4;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes, low two bits always 2'b11
  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_e;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load and store sizes, bit 2 marks the unsigned loads
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // alu selections for op and op_imm
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // sub and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [19:0] imm_hi;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_type_t;

  // i, s, b and j immediates are pieced together from the r view
  typedef union packed {
    r_type_t r;
    u_type_t u;
  } insn_t;

endpackage
